//--- alu.sv
`timescale 1ns/1ns
`include "alu_config.svh"

module alu (
  input  logic                clk,
  input  logic                rst,
  input  logic                start,
  input  alu_pkg::alu_req_t   req,
  output alu_pkg::data_t      result,
  output logic                div_done,
  input  logic                mul_en,
  output alu_pkg::mul_part_t  mul_part
);
  import alu_pkg::*;

  localparam int W = `ALU_DATA_W;

  logic op_add, op_sub, op_slt, op_sltu, op_and, op_nor, op_or, op_xor;
  logic op_sll, op_srl, op_sra, op_lui, op_mulh;
  logic op_div, op_divu, op_mod, op_modu;

  logic        use_sub;
  logic        is_div;
  logic        div_start;
  data_t       adder_b;
  data_t       adder_res;
  logic        adder_cout;
  data_t       slt_res;
  data_t       sltu_res;
  logic [4:0]  shamt;
  logic [2*W-1:0] sr64;
  data_t       div_quo;
  data_t       div_rem;

  assign op_add  = req.op[`ALU_OP_ADD];
  assign op_sub  = req.op[`ALU_OP_SUB];
  assign op_slt  = req.op[`ALU_OP_SLT];
  assign op_sltu = req.op[`ALU_OP_SLTU];
  assign op_and  = req.op[`ALU_OP_AND];
  assign op_nor  = req.op[`ALU_OP_NOR];
  assign op_or   = req.op[`ALU_OP_OR];
  assign op_xor  = req.op[`ALU_OP_XOR];
  assign op_sll  = req.op[`ALU_OP_SLL];
  assign op_srl  = req.op[`ALU_OP_SRL];
  assign op_sra  = req.op[`ALU_OP_SRA];
  assign op_lui  = req.op[`ALU_OP_LUI];
  assign op_mulh = req.op[`ALU_OP_MULH];
  assign op_div  = req.op[`ALU_OP_DIV];
  assign op_divu = req.op[`ALU_OP_DIVU];
  assign op_mod  = req.op[`ALU_OP_MOD];
  assign op_modu = req.op[`ALU_OP_MODU];

  // shared adder, src1 + ~src2 + 1 for sub and compares
  assign use_sub = op_sub | op_slt | op_sltu;
  assign adder_b = use_sub ? ~req.src2 : req.src2;
  assign {adder_cout, adder_res} = {1'b0, req.src1} + {1'b0, adder_b} + {{W{1'b0}}, use_sub};

  assign slt_res  = {{(W-1){1'b0}},
                     (req.src1[W-1] & ~req.src2[W-1])
                     | (~(req.src1[W-1] ^ req.src2[W-1]) & adder_res[W-1])};
  assign sltu_res = {{(W-1){1'b0}}, ~adder_cout};  // borrow out

  assign shamt = req.src2[4:0];
  assign sr64  = {{W{op_sra & req.src1[W-1]}}, req.src1} >> shamt;

  // a divide leaving execute drops start so a following divide restarts
  assign is_div    = op_div | op_divu | op_mod | op_modu;
  assign div_start = start & is_div & ~mul_en;

  alu_div alu_div_inst (
    .clk       (clk),
    .rst       (rst),
    .start     (div_start),
    .is_signed (op_div | op_mod),
    .dividend  (req.src1),
    .divisor   (req.src2),
    .quotient  (div_quo),
    .remainder (div_rem),
    .done      (div_done)
  );

  alu_mul alu_mul_inst (
    .clk       (clk),
    .rst       (rst),
    .en        (mul_en),
    .is_signed (op_mulh),
    .a         (req.src1),
    .b         (req.src2),
    .part      (mul_part)
  );

  // mul ops give 0 here, memory stage fills them in
  assign result = ({W{op_add | op_sub}}   & adder_res)
                | ({W{op_slt}}            & slt_res)
                | ({W{op_sltu}}           & sltu_res)
                | ({W{op_and}}            & (req.src1 & req.src2))
                | ({W{op_nor}}            & ~(req.src1 | req.src2))
                | ({W{op_or}}             & (req.src1 | req.src2))
                | ({W{op_xor}}            & (req.src1 ^ req.src2))
                | ({W{op_sll}}            & (req.src1 << shamt))
                | ({W{op_srl | op_sra}}   & sr64[W-1:0])
                | ({W{op_lui}}            & req.src2)
                | ({W{op_div | op_divu}}  & div_quo)
                | ({W{op_mod | op_modu}}  & div_rem);

  a_op_onehot: assert property (
    @(posedge clk) disable iff (rst) start |-> $onehot(req.op)
  ) else $error("operation not one-hot in execute");

endmodule

//--- alu_config.svh
`ifndef ALU_CONFIG_SVH
`define ALU_CONFIG_SVH

`define ALU_DATA_W    32  // operand and result width
`define ALU_OP_W      19  // one-hot operation vector
`define ALU_TAG_W     4

// bit positions in the one-hot operation vector
`define ALU_OP_ADD    0
`define ALU_OP_SUB    1
`define ALU_OP_SLT    2
`define ALU_OP_SLTU   3
`define ALU_OP_AND    4
`define ALU_OP_NOR    5
`define ALU_OP_OR     6
`define ALU_OP_XOR    7
`define ALU_OP_SLL    8
`define ALU_OP_SRL    9
`define ALU_OP_SRA    10
`define ALU_OP_LUI    11
`define ALU_OP_MUL    12
`define ALU_OP_MULH   13
`define ALU_OP_MULHU  14
`define ALU_OP_DIV    15
`define ALU_OP_DIVU   16
`define ALU_OP_MOD    17
`define ALU_OP_MODU   18

`define ALU_DIV_ITER  32  // one quotient bit per step

`endif

//--- alu_div.sv
`timescale 1ns/1ns
`include "alu_config.svh"

module alu_div (
  input  logic            clk,
  input  logic            rst,
  input  logic            start,
  input  logic            is_signed,
  input  alu_pkg::data_t  dividend,
  input  alu_pkg::data_t  divisor,
  output alu_pkg::data_t  quotient,
  output alu_pkg::data_t  remainder,
  output logic            done
);
  import alu_pkg::*;

  localparam int W     = `ALU_DATA_W;
  localparam int CNT_W = $clog2(`ALU_DIV_ITER);

  div_state_e       state;
  logic [CNT_W-1:0] cnt;
  data_t            quo;  // dividend shifts out, quotient shifts in
  data_t            rem;
  data_t            dsr;
  logic             neg_q;
  logic             neg_r;
  logic             div_zero;

  logic             a_neg;
  logic             b_neg;
  data_t            abs_a;
  data_t            abs_b;
  logic [W:0]       part_rem;
  logic [W:0]       diff;

  assign a_neg = is_signed & dividend[W-1];
  assign b_neg = is_signed & divisor[W-1];
  assign abs_a = a_neg ? -dividend : dividend;
  assign abs_b = b_neg ? -divisor : divisor;

  // one restoring step
  assign part_rem = {rem, quo[W-1]};
  assign diff     = part_rem - {1'b0, dsr};

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= DIV_IDLE;
    end else begin
      case (state)
        DIV_IDLE: begin
          if (start) begin
            state <= DIV_BUSY;
          end
        end
        DIV_BUSY: begin
          if (cnt == CNT_W'(`ALU_DIV_ITER - 1)) begin
            state <= DIV_DONE;
          end
        end
        DIV_DONE: begin
          if (!start) begin  // held until the requester lets go
            state <= DIV_IDLE;
          end
        end
        default: state <= DIV_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == DIV_IDLE && start) begin
      quo      <= abs_a;
      rem      <= '0;
      dsr      <= abs_b;
      cnt      <= '0;
      neg_q    <= a_neg ^ b_neg;
      neg_r    <= a_neg;  // remainder follows the dividend
      div_zero <= (divisor == '0);
    end else if (state == DIV_BUSY) begin
      cnt <= cnt + CNT_W'(1);
      rem <= diff[W] ? part_rem[W-1:0] : diff[W-1:0];
      quo <= {quo[W-2:0], ~diff[W]};
    end
  end

  // min / -1 needs no special case: |min| / 1 wraps back to min, rem 0.
  // by zero the steps already leave |dividend| in rem
  assign quotient  = div_zero ? '1 : (neg_q ? -quo : quo);
  assign remainder = neg_r ? -rem : rem;
  assign done      = (state == DIV_DONE);

  a_no_start_busy: assert property (
    @(posedge clk) disable iff (rst) (state == DIV_BUSY) |-> !$rose(start)
  ) else $error("divider start rose while busy");

endmodule

//--- alu_mul.sv
`timescale 1ns/1ns
`include "alu_config.svh"

module alu_mul (
  input  logic                clk,
  input  logic                rst,
  input  logic                en,
  input  logic                is_signed,
  input  alu_pkg::data_t      a,
  input  alu_pkg::data_t      b,
  output alu_pkg::mul_part_t  part
);
  import alu_pkg::*;

  localparam int H = `ALU_DATA_W / 2;
  localparam int P = H + 2;  // signed half width, one bit spare

  logic [`ALU_DATA_W:0] a_ext;  // 33-bit operands
  logic [`ALU_DATA_W:0] b_ext;
  logic signed [P-1:0]  a_lo;
  logic signed [P-1:0]  a_hi;
  logic signed [P-1:0]  b_lo;
  logic signed [P-1:0]  b_hi;

  // only mulh treats the operands as signed
  assign a_ext = {is_signed & a[`ALU_DATA_W-1], a};
  assign b_ext = {is_signed & b[`ALU_DATA_W-1], b};

  assign a_lo = {2'b00, a_ext[H-1:0]};  // low half always unsigned
  assign b_lo = {2'b00, b_ext[H-1:0]};
  assign a_hi = {a_ext[`ALU_DATA_W], a_ext[`ALU_DATA_W:H]};  // 17-bit signed high half
  assign b_hi = {b_ext[`ALU_DATA_W], b_ext[`ALU_DATA_W:H]};

  always_ff @(posedge clk) begin
    if (rst) begin
      part <= '0;
    end else if (en) begin  // loads as the instruction enters memory
      part[0] <= a_lo * b_lo;
      part[1] <= a_lo * b_hi;
      part[2] <= a_hi * b_lo;
      part[3] <= a_hi * b_hi;
    end
  end

endmodule

//--- alu_pipe_top.sv
`timescale 1ns/1ns

module alu_pipe_top (
  input  logic               clk,
  input  logic               rst,
  input  logic               in_valid,
  input  alu_pkg::alu_req_t  in_req,
  output logic               in_allowin,
  output logic               out_valid,
  output alu_pkg::alu_rsp_t  out_rsp,
  input  logic               out_allowin
);
  import alu_pkg::*;

  logic        exe_to_mem_valid;
  exe_to_mem_t exe_to_mem;
  mul_part_t   mul_part;
  logic        mem_allowin;

  exe_stage exe_stage_inst (
    .clk              (clk),
    .rst              (rst),
    .in_valid         (in_valid),
    .in_req           (in_req),
    .in_allowin       (in_allowin),
    .mem_allowin      (mem_allowin),
    .exe_to_mem_valid (exe_to_mem_valid),
    .exe_to_mem       (exe_to_mem),
    .mul_part         (mul_part)
  );

  mem_stage mem_stage_inst (
    .clk              (clk),
    .rst              (rst),
    .exe_to_mem_valid (exe_to_mem_valid),
    .exe_to_mem       (exe_to_mem),
    .mul_part         (mul_part),
    .mem_allowin      (mem_allowin),
    .out_valid        (out_valid),
    .out_allowin      (out_allowin),
    .out_rsp          (out_rsp)
  );

endmodule

//--- alu_pkg.sv
`include "alu_config.svh"

package alu_pkg;

  typedef logic [`ALU_DATA_W-1:0] data_t;
  typedef logic [`ALU_OP_W-1:0]   alu_op_t;
  typedef logic [`ALU_TAG_W-1:0]  tag_t;

  // ll, lh, hl, hh products of 17-bit signed halves
  typedef logic [3:0][`ALU_DATA_W+1:0] mul_part_t;

  typedef struct packed {
    alu_op_t op;
    data_t   src1;
    data_t   src2;
    tag_t    tag;
  } alu_req_t;

  typedef struct packed {
    data_t result;
    tag_t  tag;
  } alu_rsp_t;

  typedef struct packed {
    alu_op_t op;
    data_t   alu_result;
    tag_t    tag;
  } exe_to_mem_t;

  typedef enum logic [1:0] {
    DIV_IDLE,
    DIV_BUSY,
    DIV_DONE
  } div_state_e;

  // second multiplier half, sums the weighted partial products
  function automatic logic [2*`ALU_DATA_W-1:0] mul_sum(mul_part_t part);
    logic signed [2*`ALU_DATA_W-1:0] ll;
    logic signed [2*`ALU_DATA_W-1:0] lh;
    logic signed [2*`ALU_DATA_W-1:0] hl;
    logic signed [2*`ALU_DATA_W-1:0] hh;
    ll = signed'(part[0]);  // sign extend to 64 bits
    lh = signed'(part[1]);
    hl = signed'(part[2]);
    hh = signed'(part[3]);
    return ll + (lh << (`ALU_DATA_W/2)) + (hl << (`ALU_DATA_W/2)) + (hh << `ALU_DATA_W);
  endfunction

endpackage

//--- exe_stage.sv
`timescale 1ns/1ns
`include "alu_config.svh"

module exe_stage (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  in_valid,
  input  alu_pkg::alu_req_t     in_req,
  output logic                  in_allowin,
  input  logic                  mem_allowin,
  output logic                  exe_to_mem_valid,
  output alu_pkg::exe_to_mem_t  exe_to_mem,
  output alu_pkg::mul_part_t    mul_part
);
  import alu_pkg::*;

  logic     exe_valid;
  alu_req_t exe_req;
  logic     exe_is_div;
  logic     exe_ready_go;
  logic     exe_advance;
  logic     div_done;
  data_t    alu_result;

  assign exe_is_div = exe_req.op[`ALU_OP_DIV] | exe_req.op[`ALU_OP_DIVU]
                    | exe_req.op[`ALU_OP_MOD] | exe_req.op[`ALU_OP_MODU];

  assign exe_ready_go     = ~exe_is_div | div_done;  // divides wait for the divider
  assign in_allowin       = ~exe_valid | (exe_ready_go & mem_allowin);
  assign exe_to_mem_valid = exe_valid & exe_ready_go;
  assign exe_advance      = exe_to_mem_valid & mem_allowin;

  always_ff @(posedge clk) begin
    if (rst) begin
      exe_valid <= 1'b0;
    end else if (in_allowin) begin
      exe_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_allowin) begin
      exe_req <= in_req;
    end
  end

  alu alu_inst (
    .clk      (clk),
    .rst      (rst),
    .start    (exe_valid),
    .req      (exe_req),
    .result   (alu_result),
    .div_done (div_done),
    .mul_en   (exe_advance),  // partial products load with the memory register
    .mul_part (mul_part)
  );

  assign exe_to_mem = '{op: exe_req.op, alu_result: alu_result, tag: exe_req.tag};

  // a fresh divide must wait for its own divider run
  a_exe_hold: assert property (
    @(posedge clk) disable iff (rst) (in_valid && in_allowin) |=> !(exe_is_div && div_done)
  ) else $error("divide in execute was ready to go before the divider ran");

endmodule

//--- filelist.f
+incdir+.
alu_pkg.sv
alu_mul.sv
alu_div.sv
alu.sv
exe_stage.sv
mem_stage.sv
alu_pipe_top.sv
tb_alu_pipe.sv

//--- mem_stage.sv
`timescale 1ns/1ns
`include "alu_config.svh"

module mem_stage (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  exe_to_mem_valid,
  input  alu_pkg::exe_to_mem_t  exe_to_mem,
  input  alu_pkg::mul_part_t    mul_part,
  output logic                  mem_allowin,
  output logic                  out_valid,
  input  logic                  out_allowin,
  output alu_pkg::alu_rsp_t     out_rsp
);
  import alu_pkg::*;

  logic                     mem_valid;
  exe_to_mem_t              mem_reg;
  logic [2*`ALU_DATA_W-1:0] prod;
  data_t                    rsp_result;

  assign mem_allowin = ~mem_valid | out_allowin;  // always ready to go
  assign out_valid   = mem_valid;

  always_ff @(posedge clk) begin
    if (rst) begin
      mem_valid <= 1'b0;
    end else if (mem_allowin) begin
      mem_valid <= exe_to_mem_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (exe_to_mem_valid && mem_allowin) begin
      mem_reg <= exe_to_mem;
    end
  end

  assign prod = mul_sum(mul_part);

  always_comb begin
    rsp_result = mem_reg.alu_result;
    if (mem_reg.op[`ALU_OP_MUL]) begin
      rsp_result = prod[`ALU_DATA_W-1:0];
    end else if (mem_reg.op[`ALU_OP_MULH] || mem_reg.op[`ALU_OP_MULHU]) begin
      rsp_result = prod[2*`ALU_DATA_W-1:`ALU_DATA_W];  // high word
    end
  end

  assign out_rsp = '{result: rsp_result, tag: mem_reg.tag};

  a_rsp_hold: assert property (
    @(posedge clk) disable iff (rst)
    (out_valid && !out_allowin) |=> (out_valid && $stable(out_rsp))
  ) else $error("response changed while the output was stalled");

endmodule

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -j 0 \
  --top-module tb_alu_pipe -f filelist.f -o sim_tb

# the log decides pass or fail, not the exit code of the run
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -qx "=== PASS ===" sim.log; then
  exit 0
fi
exit 1

//--- tb_alu_pipe.sv
`timescale 1ns/1ns
`include "alu_config.svh"

module tb_alu_pipe;
  import alu_pkg::*;

  localparam int N_REQ       = 2 + 300 + 135 + 132 + 100 + 200;
  localparam int CYCLE_LIMIT = N_REQ * 45 + 200;

  logic     clk = 1'b0;
  logic     rst = 1'b1;
  logic     in_valid = 1'b0;
  alu_req_t in_req = '0;
  logic     in_allowin;
  logic     out_valid;
  alu_rsp_t out_rsp;
  logic     out_allowin = 1'b1;

  alu_rsp_t exp_q[$];       // model results in request order
  int       exp_test_q[$];
  alu_rsp_t exp_head = '0;
  logic     exp_valid = 1'b0;
  int       exp_test = 0;
  logic     acc_fast_d1 = 1'b0;  // non-divide accepted on the last edge
  logic     stall_on = 1'b0;
  int       test_id = 0;
  int       cycles = 0;
  int       mismatches = 0;
  int       other_errors = 0;
  tag_t     next_tag = '0;
  string    test_names[6] = '{"directed", "multiply", "divide", "backpressure",
                              "random_mix", "reset_order"};
  data_t    corners[5] = '{32'h0000_0000, 32'hffff_ffff, 32'h8000_0000,
                           32'h7fff_ffff, 32'h0000_001f};

  alu_pipe_top alu_pipe_top_inst (
    .clk         (clk),
    .rst         (rst),
    .in_valid    (in_valid),
    .in_req      (in_req),
    .in_allowin  (in_allowin),
    .out_valid   (out_valid),
    .out_rsp     (out_rsp),
    .out_allowin (out_allowin)
  );

  always #2 clk = ~clk;

  function automatic logic is_div_op(alu_op_t op);
    return op[`ALU_OP_DIV] | op[`ALU_OP_DIVU] | op[`ALU_OP_MOD] | op[`ALU_OP_MODU];
  endfunction

  function automatic int op_index(alu_op_t op);
    for (int k = 0; k < `ALU_OP_W; k++) begin
      if (op[k]) return k;
    end
    return -1;
  endfunction

  function automatic data_t model_result(int idx, data_t a, data_t b);
    logic [63:0] prod_s;
    logic [63:0] prod_u;
    data_t       smin;
    smin   = 32'h8000_0000;
    prod_s = {{32{a[31]}}, a} * {{32{b[31]}}, b};  // low 64 bits of the signed product
    prod_u = {32'h0, a} * {32'h0, b};
    case (idx)
      `ALU_OP_ADD:   return a + b;
      `ALU_OP_SUB:   return a - b;
      `ALU_OP_SLT:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      `ALU_OP_SLTU:  return (a < b) ? 32'd1 : 32'd0;
      `ALU_OP_AND:   return a & b;
      `ALU_OP_NOR:   return ~(a | b);
      `ALU_OP_OR:    return a | b;
      `ALU_OP_XOR:   return a ^ b;
      `ALU_OP_SLL:   return a << b[4:0];
      `ALU_OP_SRL:   return a >> b[4:0];
      `ALU_OP_SRA:   return $signed(a) >>> b[4:0];
      `ALU_OP_LUI:   return b;
      `ALU_OP_MUL:   return prod_u[31:0];
      `ALU_OP_MULH:  return prod_s[63:32];
      `ALU_OP_MULHU: return prod_u[63:32];
      `ALU_OP_DIV: begin
        if (b == 32'h0) return 32'hffff_ffff;
        if (a == smin && b == 32'hffff_ffff) return smin;
        return $signed(a) / $signed(b);
      end
      `ALU_OP_DIVU:  return (b == 32'h0) ? 32'hffff_ffff : a / b;
      `ALU_OP_MOD: begin
        if (b == 32'h0) return a;
        if (a == smin && b == 32'hffff_ffff) return 32'h0;
        return $signed(a) % $signed(b);  // sign follows the dividend
      end
      `ALU_OP_MODU:  return (b == 32'h0) ? a : a % b;
      default:       return 32'h0;
    endcase
  endfunction

  function automatic data_t rand_divisor();
    data_t d;
    d = $urandom >> ($urandom % 32);  // spread of magnitudes
    if ($urandom % 2)
      d = -d;
    return d;
  endfunction

  // scoreboard side, pop before push since latency is at least two
  always @(posedge clk) begin : scoreboard
    alu_rsp_t pushed;
    if (!rst && out_valid && out_allowin && exp_q.size() != 0) begin
      void'(exp_q.pop_front());
      void'(exp_test_q.pop_front());
    end
    if (!rst && in_valid && in_allowin) begin
      pushed.result = model_result(op_index(in_req.op), in_req.src1, in_req.src2);
      pushed.tag    = in_req.tag;
      exp_q.push_back(pushed);
      exp_test_q.push_back(test_id);
    end
    acc_fast_d1 <= !rst && in_valid && in_allowin && !is_div_op(in_req.op);
    exp_valid   <= (exp_q.size() != 0);
    if (exp_q.size() != 0) begin
      exp_head <= exp_q[0];
      exp_test <= exp_test_q[0];
    end
  end

  always @(posedge clk) begin
    #1;
    out_allowin = stall_on ? ($urandom_range(2, 0) != 0) : 1'b1;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      other_errors++;
      $display("timeout after %0d cycles, %0d responses still outstanding",
               cycles, exp_q.size());
      $display("results: %0d mismatches, %0d other errors", mismatches, other_errors);
      $display("=== FAIL ===");
      $finish;
    end
  end

  a_rsp_expected: assert property (
    @(posedge clk) disable iff (rst) (out_valid && out_allowin) |-> exp_valid
  ) else begin
    other_errors++;
    $display("a response left the pipeline with no request outstanding");
  end

  a_rsp_match: assert property (
    @(posedge clk) disable iff (rst)
    (out_valid && out_allowin && exp_valid) |-> (out_rsp == exp_head)
  ) else begin
    mismatches++;
    $display("Mismatch %s: expected result %h tag %h, actual result %h tag %h",
             test_names[$sampled(exp_test)], $sampled(exp_head.result),
             $sampled(exp_head.tag), $sampled(out_rsp.result), $sampled(out_rsp.tag));
  end

  a_fast_latency: assert property (
    @(posedge clk) disable iff (rst) (acc_fast_d1 && out_allowin) |=> out_valid
  ) else begin
    other_errors++;
    $display("response did not appear two cycles after its request was accepted");
  end

  a_stall_hold: assert property (
    @(posedge clk) disable iff (rst)
    (out_valid && !out_allowin) |=> (out_valid && $stable(out_rsp))
  ) else begin
    other_errors++;
    $display("response changed or vanished while the output was stalled");
  end

  a_reset_state: assert property (
    @(posedge clk) $fell(rst) |-> (!out_valid && in_allowin)
  ) else begin
    other_errors++;
    $display("after reset the output was valid or the input was not accepting");
  end

  task automatic send_req(input int idx, input data_t a, input data_t b);
    in_valid       = 1'b1;
    in_req.op      = '0;
    in_req.op[idx] = 1'b1;
    in_req.src1    = a;
    in_req.src2    = b;
    in_req.tag     = next_tag;
    @(posedge clk);
    while (!in_allowin) @(posedge clk);
    #1;
    in_valid = 1'b0;
    next_tag = next_tag + 1'b1;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) begin
      @(posedge clk);
      #1;
    end
  endtask

  initial begin : stimulus
    int op;
    int i;
    int j;
    int t0;
    void'($urandom(32'h14f7_f069));
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;

    test_id = 5;  // divide then add, answered in that order
    send_req(`ALU_OP_DIV, 32'd100, 32'd7);
    send_req(`ALU_OP_ADD, 32'd1, 32'd2);
    wait_drain();

    test_id = 0;
    for (op = `ALU_OP_ADD; op <= `ALU_OP_LUI; op++) begin
      for (i = 0; i < 5; i++) begin
        for (j = 0; j < 5; j++) begin
          send_req(op, corners[i], corners[j]);
        end
      end
    end
    wait_drain();

    test_id = 1;
    t0 = cycles;
    for (op = `ALU_OP_MUL; op <= `ALU_OP_MULHU; op++) begin
      for (i = 0; i < 5; i++) begin
        for (j = 0; j < 5; j++) begin
          send_req(op, corners[i], corners[j]);
        end
      end
    end
    assert (cycles - t0 == 75) else begin
      other_errors++;
      $display("back-to-back multiplies were not accepted one per cycle");
    end
    for (op = `ALU_OP_MUL; op <= `ALU_OP_MULHU; op++) begin
      repeat (20) send_req(op, $urandom, $urandom);
    end
    wait_drain();

    test_id = 2;
    for (op = `ALU_OP_DIV; op <= `ALU_OP_MODU; op++) begin
      repeat (30) send_req(op, $urandom, rand_divisor());
      send_req(op, $urandom, 32'h0);
      send_req(op, 32'h8000_0000, 32'hffff_ffff);
      send_req(op, 32'h0, 32'h0);
    end
    wait_drain();

    test_id  = 3;
    stall_on = 1'b1;
    repeat (100) send_req($urandom % 15, $urandom, $urandom);
    wait_drain();
    stall_on = 1'b0;

    test_id = 4;  // all operations, gaps on the input
    repeat (200) begin
      idle_cycles($urandom % 3);
      send_req($urandom % `ALU_OP_W, $urandom, $urandom);
    end
    wait_drain();
    idle_cycles(2);

    $display("results: %0d mismatches, %0d other errors", mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule
